// File: include/cad_defines.svh
`ifndef CAD_DEFINES_SVH
`define CAD_DEFINES_SVH

// Image side, pixels per row and per column
`define CAD_IMG_SIZE 8

// Kernel side, also the number of multipliers
`define CAD_K_SIZE 5

// Signed pixel and weight width
`define CAD_PIX_W 8

// Accumulator and pooled result width
`define CAD_ACC_W 20

// Valid convolution output is CONV_SIZE x CONV_SIZE
`define CAD_CONV_SIZE 4

// One result per 2x2 pooling window
`define CAD_POOL_OUTS 4

`endif

// File: hw/cad_pkg.sv
`default_nettype none

`include "cad_defines.svh"

package cad_pkg;

  typedef logic signed [`CAD_PIX_W-1:0] pixel_t;
  typedef logic signed [`CAD_ACC_W-1:0] acc_t;
  typedef logic [$clog2(`CAD_IMG_SIZE)-1:0] coord_t;
  typedef logic [$clog2(`CAD_K_SIZE)-1:0] krow_t;
  typedef logic [$clog2(`CAD_ACC_W)-1:0] bitcnt_t;

  // One-hot job states
  typedef enum logic [3:0] {
    IDLE        = 4'b0001,
    LOAD_IMG    = 4'b0010,
    LOAD_KERNEL = 4'b0100,
    PROCESS     = 4'b1000
  } cad_state_e;

  // Destination of the incoming byte
  typedef struct packed {
    logic   sel_kernel;
    coord_t row;
    coord_t col;
  } load_pos_t;

  // Scan step, follows its operands down the pipeline
  typedef struct packed {
    coord_t row;
    coord_t col;
    krow_t  krow;
    logic   first_krow;
    logic   last_krow;
    logic   pool_first;
    logic   pool_last;
  } scan_pos_t;

  // Operands of one kernel row
  typedef struct packed {
    pixel_t [`CAD_K_SIZE-1:0] pix;
    pixel_t [`CAD_K_SIZE-1:0] wgt;
  } mac_ops_t;

endpackage

`default_nettype wire

// File: hw/cad_ctrl.sv
`default_nettype none

module cad_ctrl (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      in_valid,
  input  wire                      load_done,
  input  wire                      scan_done,
  output cad_pkg::cad_state_e      state
);

  import cad_pkg::*;

  cad_state_e state_nxt;

  // ------------------------------------------------------------------
  // Job sequencing
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state;
    unique case (state)
      IDLE:
      begin
        // First image byte arrives together with the leaving of idle
        if (in_valid)
          state_nxt = LOAD_IMG;
      end
      LOAD_IMG:
      begin
        if (load_done)
          state_nxt = LOAD_KERNEL;
      end
      LOAD_KERNEL:
      begin
        if (load_done)
          state_nxt = PROCESS;
      end
      PROCESS:
      begin
        if (scan_done)
          state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/cad_counter.sv
`default_nettype none

`include "cad_defines.svh"

module cad_counter (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire cad_pkg::cad_state_e state,
  input  wire                      in_valid,
  output cad_pkg::load_pos_t       load_pos,
  output logic                     load_done,
  output cad_pkg::scan_pos_t       scan_pos,
  output logic                     scan_valid,
  output logic                     scan_done
);

  import cad_pkg::*;

  localparam coord_t IMG_LAST     = coord_t'(`CAD_IMG_SIZE - 1);
  localparam coord_t K_LAST       = coord_t'(`CAD_K_SIZE - 1);
  localparam krow_t  KROW_LAST    = krow_t'(`CAD_K_SIZE - 1);
  localparam coord_t WIN_COL_LAST = coord_t'(`CAD_CONV_SIZE - 2);
  localparam int     WIN_CNT_W    = $clog2(`CAD_POOL_OUTS);
  localparam logic [WIN_CNT_W-1:0] WIN_CNT_LAST = WIN_CNT_W'(`CAD_POOL_OUTS - 1);

  logic                 load_active;
  coord_t               load_last;
  krow_t                krow;
  logic                 pos_x;
  logic                 pos_y;
  coord_t               win_row;
  coord_t               win_col;
  logic [WIN_CNT_W-1:0] win_cnt;

  // ------------------------------------------------------------------
  // Load addressing, 8x8 image then 5x5 kernel
  // ------------------------------------------------------------------
  assign load_active = in_valid && (state inside {IDLE, LOAD_IMG, LOAD_KERNEL});
  assign load_last   = load_pos.sel_kernel ? K_LAST : IMG_LAST;
  assign load_done   = in_valid && (state inside {LOAD_IMG, LOAD_KERNEL})
                       && (load_pos.row == load_last) && (load_pos.col == load_last);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      load_pos <= '0;
    end
    else if (load_active)
    begin
      if (load_done)
      begin
        // Kernel follows the image, then back to image for the next job
        load_pos.sel_kernel <= (state == LOAD_IMG);
        load_pos.row        <= '0;
        load_pos.col        <= '0;
      end
      else if (load_pos.col == load_last)
      begin
        load_pos.col <= '0;
        load_pos.row <= load_pos.row + 1'b1;
      end
      else
      begin
        load_pos.col <= load_pos.col + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Scan order: kernel rows, then 2x2 positions, then windows
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      krow    <= '0;
      pos_x   <= 1'b0;
      pos_y   <= 1'b0;
      win_row <= '0;
      win_col <= '0;
      win_cnt <= '0;
    end
    else if (state != PROCESS)
    begin
      krow    <= '0;
      pos_x   <= 1'b0;
      pos_y   <= 1'b0;
      win_row <= '0;
      win_col <= '0;
      win_cnt <= '0;
    end
    else if (krow != KROW_LAST)
    begin
      krow <= krow + 1'b1;
    end
    else
    begin
      krow <= '0;
      if (pos_x && pos_y)
      begin
        pos_x   <= 1'b0;
        pos_y   <= 1'b0;
        win_cnt <= win_cnt + 1'b1;
        // Windows step by two across the conv output
        if (win_col == WIN_COL_LAST)
        begin
          win_col <= '0;
          win_row <= win_row + coord_t'(2);
        end
        else
        begin
          win_col <= win_col + coord_t'(2);
        end
      end
      else if (pos_x)
      begin
        pos_x <= 1'b0;
        pos_y <= 1'b1;
      end
      else
      begin
        pos_x <= 1'b1;
      end
    end
  end

  always_comb
  begin
    scan_pos.row        = win_row + coord_t'(pos_y);
    scan_pos.col        = win_col + coord_t'(pos_x);
    scan_pos.krow       = krow;
    scan_pos.first_krow = (krow == '0);
    scan_pos.last_krow  = (krow == KROW_LAST);
    scan_pos.pool_first = !pos_x && !pos_y;
    scan_pos.pool_last  = pos_x && pos_y;
  end

  assign scan_valid = (state == PROCESS);
  assign scan_done  = scan_valid && scan_pos.last_krow && scan_pos.pool_last
                      && (win_cnt == WIN_CNT_LAST);

endmodule

`default_nettype wire

// File: hw/cad_matrix_store.sv
`default_nettype none

`include "cad_defines.svh"

module cad_matrix_store (
  input  wire                     clk,
  input  wire                     in_valid,
  input  wire cad_pkg::pixel_t    matrix,
  input  wire cad_pkg::load_pos_t load_pos,
  input  wire cad_pkg::scan_pos_t scan_pos,
  input  wire                     scan_valid,
  output cad_pkg::mac_ops_t       ops,
  output cad_pkg::scan_pos_t      ops_pos,
  output logic                    ops_valid
);

  import cad_pkg::*;

  pixel_t img_mem [`CAD_IMG_SIZE][`CAD_IMG_SIZE];
  pixel_t k_mem   [`CAD_K_SIZE][`CAD_K_SIZE];
  coord_t rd_row;

  // Image row under the current kernel row
  assign rd_row = scan_pos.row + coord_t'(scan_pos.krow);

  // Input bytes are dropped while the scan runs
  always_ff @(posedge clk)
  begin
    if (in_valid && !scan_valid)
    begin
      if (load_pos.sel_kernel)
        k_mem[load_pos.row][load_pos.col] <= matrix;
      else
        img_mem[load_pos.row][load_pos.col] <= matrix;
    end
  end

  // Five pixels and one kernel row per step
  always_ff @(posedge clk)
  begin
    if (scan_valid)
    begin
      for (int i = 0; i < `CAD_K_SIZE; i++)
      begin
        ops.pix[i] <= img_mem[rd_row][scan_pos.col + coord_t'(i)];
        ops.wgt[i] <= k_mem[scan_pos.krow][coord_t'(i)];
      end
    end
    ops_pos   <= scan_pos;
    ops_valid <= scan_valid;
  end

endmodule

`default_nettype wire

// File: hw/cad_mac.sv
`default_nettype none

`include "cad_defines.svh"

module cad_mac (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire cad_pkg::mac_ops_t  ops,
  input  wire cad_pkg::scan_pos_t ops_pos,
  input  wire                     ops_valid,
  output logic                    pool_valid,
  output cad_pkg::acc_t           pool_max
);

  import cad_pkg::*;

  acc_t      row_prod;
  acc_t      row_sum;
  scan_pos_t sum_pos;
  logic      sum_valid;
  acc_t      acc;
  acc_t      full_sum;
  acc_t      run_max;
  acc_t      win_max;

  // ------------------------------------------------------------------
  // Stage 2: five signed products of one kernel row
  // ------------------------------------------------------------------
  always_comb
  begin
    row_prod = '0;
    for (int i = 0; i < `CAD_K_SIZE; i++)
    begin
      row_prod = row_prod
                 + acc_t'($signed(ops.pix[i])) * acc_t'($signed(ops.wgt[i]));
    end
  end

  always_ff @(posedge clk)
  begin
    row_sum <= row_prod;
    sum_pos <= ops_pos;
  end

  // ------------------------------------------------------------------
  // Row accumulation and 2x2 max pooling
  // ------------------------------------------------------------------
  assign full_sum = acc + row_sum;
  // First position of a window restarts the max
  assign win_max  = (sum_pos.pool_first || (full_sum > run_max)) ? full_sum : run_max;

  always_ff @(posedge clk)
  begin
    if (sum_valid)
    begin
      acc <= sum_pos.first_krow ? row_sum : full_sum;
      if (sum_pos.last_krow)
        run_max <= win_max;
    end
    pool_max <= win_max;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sum_valid  <= 1'b0;
      pool_valid <= 1'b0;
    end
    else
    begin
      sum_valid  <= ops_valid;
      pool_valid <= sum_valid && sum_pos.last_krow && sum_pos.pool_last;
    end
  end

endmodule

`default_nettype wire

// File: hw/cad_serializer.sv
`default_nettype none

`include "cad_defines.svh"

module cad_serializer (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 pool_valid,
  input  wire cad_pkg::acc_t  pool_max,
  output logic                out_valid,
  output logic                out_value
);

  import cad_pkg::*;

  localparam bitcnt_t BIT_LAST = bitcnt_t'(`CAD_ACC_W - 1);

  acc_t    shift_q;
  bitcnt_t bit_cnt;

  // Remaining bits of the result, LSB first
  always_ff @(posedge clk)
  begin
    if (pool_valid)
      shift_q <= pool_max >> 1;
    else if (out_valid)
      shift_q <= shift_q >> 1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      out_value <= 1'b0;
      bit_cnt   <= '0;
    end
    else if (pool_valid)
    begin
      // New result takes over right after the last bit of the previous one
      out_valid <= 1'b1;
      out_value <= pool_max[0];
      bit_cnt   <= '0;
    end
    else if (out_valid)
    begin
      if (bit_cnt == BIT_LAST)
      begin
        out_valid <= 1'b0;
        out_value <= 1'b0;
      end
      else
      begin
        out_value <= shift_q[0];
        bit_cnt   <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cad_top.sv
`default_nettype none

module cad_top (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  in_valid,
  input  wire cad_pkg::pixel_t matrix,
  output logic                 out_valid,
  output logic                 out_value
);

  import cad_pkg::*;

  cad_state_e state;
  load_pos_t  load_pos;
  logic       load_done;
  scan_pos_t  scan_pos;
  logic       scan_valid;
  logic       scan_done;
  mac_ops_t   ops;
  scan_pos_t  ops_pos;
  logic       ops_valid;
  logic       pool_valid;
  acc_t       pool_max;

  // ------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------
  cad_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .load_done (load_done),
    .scan_done (scan_done),
    .state     (state)
  );

  cad_counter u_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .in_valid   (in_valid),
    .load_pos   (load_pos),
    .load_done  (load_done),
    .scan_pos   (scan_pos),
    .scan_valid (scan_valid),
    .scan_done  (scan_done)
  );

  // ------------------------------------------------------------------
  // Datapath: operand fetch, MAC and pooling, serial output
  // ------------------------------------------------------------------
  cad_matrix_store u_store (
    .clk        (clk),
    .in_valid   (in_valid),
    .matrix     (matrix),
    .load_pos   (load_pos),
    .scan_pos   (scan_pos),
    .scan_valid (scan_valid),
    .ops        (ops),
    .ops_pos    (ops_pos),
    .ops_valid  (ops_valid)
  );

  cad_mac u_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .ops        (ops),
    .ops_pos    (ops_pos),
    .ops_valid  (ops_valid),
    .pool_valid (pool_valid),
    .pool_max   (pool_max)
  );

  cad_serializer u_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .pool_valid (pool_valid),
    .pool_max   (pool_max),
    .out_valid  (out_valid),
    .out_value  (out_value)
  );

endmodule

`default_nettype wire

// File: tb/cad_assertions.sv
`default_nettype none

`include "cad_defines.svh"

module cad_assertions (
  input wire clk,
  input wire rst_n,
  input wire out_valid,
  input wire out_value
);

  // Four results of ACC_W bits each, back to back
  localparam int RUN_LEN = `CAD_POOL_OUTS * `CAD_ACC_W;

  int run_len;

  // Consecutive cycles with out_valid high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      run_len <= 0;
    else if (out_valid)
      run_len <= run_len + 1;
    else
      run_len <= 0;
  end

  // ------------------------------------------------------------------
  // Output protocol
  // ------------------------------------------------------------------
  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while rst_n is low");

  a_burst_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (run_len < RUN_LEN))
    else $error("out_valid high for more than %0d cycles", RUN_LEN);

  a_burst_length: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(out_valid) |-> (run_len == RUN_LEN))
    else $error("out_valid burst of %0d cycles, %0d required", run_len, RUN_LEN);

  a_value_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid |-> !out_value)
    else $error("out_value high while out_valid is low");

endmodule

bind cad_top cad_assertions u_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .out_value (out_value)
);

`default_nettype wire

// File: tb/tb_cad.sv
`default_nettype none

`include "cad_defines.svh"

module tb_cad;

  localparam int N_TESTS   = 7;
  localparam int JOB_LIMIT = 250;
  localparam int MAX_LAT   = 30;
  localparam int BURST     = `CAD_POOL_OUTS * `CAD_ACC_W;
  localparam int CONV      = `CAD_CONV_SIZE;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  logic [7:0]           matrix;
  logic                 out_valid;
  logic                 out_value;

  int                   seed;
  int                   img [`CAD_IMG_SIZE][`CAD_IMG_SIZE];
  int                   ker [`CAD_K_SIZE][`CAD_K_SIZE];
  int                   exp_q [`CAD_POOL_OUTS];
  int                   got_q [$];
  string                test_name;
  int                   err_cnt;
  int                   pass_cnt;
  int                   fail_cnt;
  logic [`CAD_ACC_W-1:0] bits;
  int                   bit_idx;
  int                   run_len;

  cad_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .matrix    (matrix),
    .out_valid (out_valid),
    .out_value (out_value)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic report_value(input string what, input int expected, input int actual);
    $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
    err_cnt++;
  endtask

  task automatic report_fail(input string msg);
    $display("%s: %s", test_name, msg);
    err_cnt++;
  endtask

  task automatic finish_test(input int start_err);
    if (err_cnt == start_err)
    begin
      pass_cnt++;
      $display("Test %s: pass", test_name);
    end
    else
    begin
      fail_cnt++;
      $display("Test %s: fail", test_name);
    end
  endtask

  // ------------------------------------------------------------------
  // Output monitor sampled on the falling edge
  // ------------------------------------------------------------------
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      assert (!out_valid) else report_fail("out_valid high during reset");
      bit_idx = 0;
      run_len = 0;
    end
    else if (out_valid)
    begin
      bits[bit_idx] = out_value;
      run_len++;
      // LSB arrives first
      if (bit_idx == `CAD_ACC_W - 1)
      begin
        got_q.push_back(int'($signed(bits)));
        bit_idx = 0;
      end
      else
        bit_idx++;
    end
    else
    begin
      assert (!out_value) else report_fail("out_value high while out_valid is low");
      if (run_len != 0)
        assert (run_len == BURST) else report_value("out_valid length", BURST, run_len);
      run_len = 0;
    end
  end

  function automatic int rand_pixel();
    logic signed [7:0] b;
    b = 8'($random(seed));
    return int'(b);
  endfunction

  // Valid convolution and then the max of each 2x2 window in raster order
  task automatic compute_ref();
    int conv [CONV][CONV];
    int wr;
    int wc;
    for (int r = 0; r < CONV; r++)
      for (int c = 0; c < CONV; c++)
      begin
        conv[r][c] = 0;
        for (int i = 0; i < `CAD_K_SIZE; i++)
          for (int j = 0; j < `CAD_K_SIZE; j++)
            conv[r][c] += img[r + i][c + j] * ker[i][j];
      end
    for (int w = 0; w < `CAD_POOL_OUTS; w++)
    begin
      wr = (w / 2) * 2;
      wc = (w % 2) * 2;
      exp_q[w] = conv[wr][wc];
      for (int dy = 0; dy < 2; dy++)
        for (int dx = 0; dx < 2; dx++)
          if (conv[wr + dy][wc + dx] > exp_q[w])
            exp_q[w] = conv[wr + dy][wc + dx];
    end
  endtask

  task automatic drive_byte(input int v);
    @(posedge clk);
    in_valid <= 1'b1;
    matrix   <= 8'(v);
  endtask

  task automatic load_job();
    for (int r = 0; r < `CAD_IMG_SIZE; r++)
      for (int c = 0; c < `CAD_IMG_SIZE; c++)
        drive_byte(img[r][c]);
    for (int r = 0; r < `CAD_K_SIZE; r++)
      for (int c = 0; c < `CAD_K_SIZE; c++)
        drive_byte(ker[r][c]);
    @(posedge clk);
    in_valid <= 1'b0;
    matrix   <= '0;
  endtask

  task automatic run_job(input string name);
    int start_err;
    int lat;
    int waited;
    test_name = name;
    start_err = err_cnt;
    compute_ref();
    load_job();
    lat = 1;
    while (run_len == 0 && lat <= JOB_LIMIT)
    begin
      @(posedge clk);
      lat++;
    end
    assert (lat <= MAX_LAT) else report_value("output latency bound", MAX_LAT, lat);
    // Job ends when four results are in and out_valid has dropped
    waited = 0;
    while (!(got_q.size() >= `CAD_POOL_OUTS && run_len == 0) && waited < JOB_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (got_q.size() < `CAD_POOL_OUTS || run_len != 0)
      report_fail("timed out waiting for four results");
    else
    begin
      assert (got_q.size() == `CAD_POOL_OUTS)
        else report_value("result count", `CAD_POOL_OUTS, got_q.size());
      for (int i = 0; i < `CAD_POOL_OUTS; i++)
        assert (got_q[i] == exp_q[i])
          else report_value($sformatf("result %0d", i), exp_q[i], got_q[i]);
    end
    got_q.delete();
    finish_test(start_err);
  endtask

  task automatic check_idle(input string name);
    int start_err;
    test_name = name;
    start_err = err_cnt;
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk);
      assert (!out_valid && !out_value) else report_fail("output active before any job");
    end
    finish_test(start_err);
  endtask

  // ------------------------------------------------------------------
  // Stimulus patterns
  // ------------------------------------------------------------------
  task automatic fill_random();
    foreach (img[r, c])
      img[r][c] = rand_pixel();
    foreach (ker[r, c])
      ker[r][c] = rand_pixel();
  endtask

  task automatic fill_const(input int img_val, input int ker_val);
    foreach (img[r, c])
      img[r][c] = img_val;
    foreach (ker[r, c])
      ker[r][c] = ker_val;
  endtask

  task automatic fill_alternating();
    fill_const(-128, 0);
    foreach (ker[r, c])
      ker[r][c] = ((r * `CAD_K_SIZE + c) % 2 == 0) ? 127 : -127;
  endtask

  // Delta kernel moves the peak to a new corner in each window
  // Peaks fall from window to window so each max has to restart
  task automatic fill_crafted();
    fill_const(0, 0);
    foreach (img[r, c])
      img[r][c] = -(r + c);
    ker[0][0] = 1;
    img[0][0] = 80;
    img[0][3] = 70;
    img[3][0] = 60;
    img[3][3] = 50;
  endtask

  initial
  begin
    seed      = 32'h1bdf347a;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    bit_idx   = 0;
    run_len   = 0;
    test_name = "reset";
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    matrix    = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    check_idle("reset_idle");
    fill_random();
    run_job("random_job");
    fill_const(-128, -128);
    run_job("extreme_positive");
    fill_alternating();
    run_job("extreme_negative");
    fill_crafted();
    run_job("pool_position");
    fill_random();
    run_job("back_to_back_1");
    fill_random();
    run_job("back_to_back_2");

    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // Watchdog allowing about 300 cycles per test
  initial
  begin
    repeat (N_TESTS * 300) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", N_TESTS * 300);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
hw/cad_pkg.sv
hw/cad_ctrl.sv
hw/cad_counter.sv
hw/cad_matrix_store.sv
hw/cad_mac.sv
hw/cad_serializer.sv
hw/cad_top.sv
tb/cad_assertions.sv
tb/tb_cad.sv

// File: Makefile
TOP := tb_cad

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
